// File: tb.f
rtl/track_pkg.sv
rtl/track_store.sv
rtl/straight_collision.sv
rtl/arc_collision.sv
rtl/car_physics.sv
rtl/race_track_top.sv
sim/tb_clock.sv
sim/race_track_props.sv
sim/race_track_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the race track testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module race_track_tb -f tb.f -o race_track_sim
./obj_dir/race_track_sim

// File: sim/race_track_tb.sv
`default_nettype none

module race_track_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int STEP_TIMEOUT = 20;
    // Six tests of up to 20 steps, 10 cycles per step, 100 ns per cycle.
    localparam int WATCHDOG_NS = 6 * 20 * 10 * 100;

    logic                                  clk;
    logic                                  reset;
    logic                                  piece_wr;
    logic [track_pkg::PIECE_IDX_WIDTH-1:0] piece_index;
    track_pkg::track_piece_t               piece;
    logic                                  load;
    track_pkg::car_state_t                 car_in;
    logic                                  step;
    track_pkg::car_state_t                 car_out;
    logic                                  done;
    logic                                  collided;
    logic                                  off_track;

    track_pkg::track_piece_t layout [track_pkg::NUM_PIECES];
    track_pkg::car_state_t   model_car;

    tb_clock u_clock (.o_clk(clk));

    race_track_top uut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_piece_wr    (piece_wr),
        .i_piece_index (piece_index),
        .i_piece       (piece),
        .i_load        (load),
        .i_car         (car_in),
        .i_step        (step),
        .o_car         (car_out),
        .o_done        (done),
        .o_collided    (collided),
        .o_off_track   (off_track)
    );

    bind car_physics race_track_props u_props (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_step  (i_step),
        .i_state (state),
        .i_done  (o_done)
    );

    function automatic track_pkg::track_piece_t make_piece(
        input track_pkg::piece_kind_e kind, input int l, input int r, input int b, input int t,
        input int cx, input int cy, input int ri, input int ro);
        track_pkg::track_piece_t p;
        p.kind         = kind;
        p.x_left       = track_pkg::COORD_WIDTH'(l);
        p.x_right      = track_pkg::COORD_WIDTH'(r);
        p.y_bottom     = track_pkg::COORD_WIDTH'(b);
        p.y_top        = track_pkg::COORD_WIDTH'(t);
        p.center_x     = track_pkg::COORD_WIDTH'(cx);
        p.center_y     = track_pkg::COORD_WIDTH'(cy);
        p.radius_inner = track_pkg::COORD_WIDTH'(ri);
        p.radius_outer = track_pkg::COORD_WIDTH'(ro);
        return p;
    endfunction

    function automatic track_pkg::car_state_t make_car(input int x, input int y,
                                                       input int vx, input int vy);
        track_pkg::car_state_t c;
        c.x  = track_pkg::COORD_WIDTH'(x);
        c.y  = track_pkg::COORD_WIDTH'(y);
        c.vx = track_pkg::VEL_WIDTH'(vx);
        c.vy = track_pkg::VEL_WIDTH'(vy);
        return c;
    endfunction

    // Reference step built from the hit rules one piece at a time.
    function automatic void predict_step(input track_pkg::car_state_t car,
        output track_pkg::car_state_t next_car, output bit hit, output bit off);
        int x, y, vx, vy, dx, dy, dot, dsq, rad, lim_in, lim_out;
        bit fx, fy, seen;
        track_pkg::track_piece_t p;
        x = car.x;
        y = car.y;
        vx = car.vx;
        vy = car.vy;
        rad = int'(track_pkg::CAR_RADIUS);
        fx = 1'b0;
        fy = 1'b0;
        seen = 1'b0;
        for (int i = 0; i < track_pkg::NUM_PIECES; i++) begin
            p = layout[i];
            if (x >= int'(p.x_left) && x <= int'(p.x_right)
                    && y >= int'(p.y_bottom) && y <= int'(p.y_top)) begin
                seen = 1'b1;
                if (p.kind == track_pkg::PIECE_HORIZONTAL) begin
                    if ((int'(p.y_top) - y - rad <= 0 && vy > 0)
                            || (y - rad - int'(p.y_bottom) <= 0 && vy < 0)) fy = 1'b1;
                end else if (p.kind == track_pkg::PIECE_VERTICAL) begin
                    if ((int'(p.x_right) - x - rad <= 0 && vx > 0)
                            || (x - rad - int'(p.x_left) <= 0 && vx < 0)) fx = 1'b1;
                end else if (p.kind == track_pkg::PIECE_ARC) begin
                    dx = x - int'(p.center_x);
                    dy = y - int'(p.center_y);
                    dsq = dx * dx + dy * dy;
                    dot = vx * dx + vy * dy;
                    lim_in = (int'(p.radius_inner) + rad) * (int'(p.radius_inner) + rad);
                    lim_out = (int'(p.radius_outer) - rad) * (int'(p.radius_outer) - rad);
                    if ((dsq <= lim_in && dot < 0) || (dsq >= lim_out && dot > 0)) begin
                        fx = 1'b1;
                        fy = 1'b1;
                    end
                end
            end
        end
        hit = fx || fy;
        off = !seen;
        next_car = hit ? make_car(x, y, fx ? -vx : vx, fy ? -vy : vy)
                       : make_car(x + vx, y + vy, vx, vy);
    endfunction

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input longint expected, input longint actual);
        if (expected != actual) begin
            stop_on_error($sformatf("CHECK FAILED [%s] %s: expected %0d, actual %0d",
                                    test_name, what, expected, actual));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
    endtask

    task automatic check_reset_values(input string name);
        check_value(name, "done", 0, done);
        check_value(name, "collided", 0, collided);
        check_value(name, "off_track", 0, off_track);
        check_value(name, "car", 0, car_out);
    endtask

    task automatic clear_layout();
        for (int i = 0; i < track_pkg::NUM_PIECES; i++) begin
            layout[i] = make_piece(track_pkg::PIECE_HORIZONTAL,
                                   -1500, -1500, -1500, -1500, 0, 0, 0, 0);
        end
    endtask

    task automatic write_layout();
        for (int i = 0; i < track_pkg::NUM_PIECES; i++) begin
            @(posedge clk);
            piece_wr    <= 1'b1;
            piece_index <= track_pkg::PIECE_IDX_WIDTH'(i);
            piece       <= layout[i];
        end
        @(posedge clk);
        piece_wr <= 1'b0;
    endtask

    task automatic load_car(input track_pkg::car_state_t c);
        @(posedge clk);
        load   <= 1'b1;
        car_in <= c;
        @(posedge clk);
        load <= 1'b0;
        @(negedge clk);
        check_value("load", "car", c, car_out);
        model_car = c;
    endtask

    // Strobes step, then waits for done; optional strobes land mid scan.
    task automatic run_step(input string name, input bit poke_busy);
        int latency;
        bit seen;
        latency = 0;
        seen = 1'b0;
        @(posedge clk);
        step <= 1'b1;
        while (!seen) begin
            @(negedge clk);
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                latency++;
                if (latency > STEP_TIMEOUT) begin
                    stop_on_error($sformatf("Test %s: no done pulse after a step", name));
                end
                @(posedge clk);
                if (poke_busy && latency == 2) begin
                    step   <= 1'b1;
                    load   <= 1'b1;
                    car_in <= make_car(700, 700, 9, 9);
                end else begin
                    step <= 1'b0;
                    load <= 1'b0;
                end
            end
        end
        check_value(name, "step latency", 6, latency);
    endtask

    task automatic step_and_check(input string name, input bit poke_busy,
                                  input bit exp_collided, input bit exp_off_track);
        track_pkg::car_state_t next_car;
        bit                    hit;
        bit                    off;
        predict_step(model_car, next_car, hit, off);
        run_step(name, poke_busy);
        check_value(name, "car", next_car, car_out);
        check_value(name, "collided", hit, collided);
        check_value(name, "off_track", off, off_track);
        check_value(name, "expected collided", exp_collided, collided);
        check_value(name, "expected off_track", exp_off_track, off_track);
        model_car = next_car;
    endtask

    task automatic free_motion_test();
        int vx;
        int vy;
        vx = int'($urandom_range(10)) - 5;
        vy = int'($urandom_range(10)) - 5;
        clear_layout();
        layout[0] = make_piece(track_pkg::PIECE_HORIZONTAL, -1000, 1000, -100, 100,
                               0, 0, 0, 0);
        write_layout();
        load_car(make_car(0, 0, vx, vy));
        repeat (10) step_and_check("free_motion", 1'b0, 1'b0, 1'b0);
    endtask

    task automatic horizontal_border_test();
        clear_layout();
        layout[1] = make_piece(track_pkg::PIECE_HORIZONTAL, -200, 200, 0, 40, 0, 0, 0, 0);
        write_layout();
        load_car(make_car(0, 38, 2, 3));
        step_and_check("horizontal_border", 1'b0, 1'b1, 1'b0);
        // Now heading away from the top border.
        step_and_check("horizontal_border", 1'b0, 1'b0, 1'b0);
    endtask

    task automatic vertical_border_test();
        clear_layout();
        layout[2] = make_piece(track_pkg::PIECE_VERTICAL, 0, 40, -200, 200, 0, 0, 0, 0);
        write_layout();
        load_car(make_car(3, 10, -2, 1));
        step_and_check("vertical_border", 1'b0, 1'b1, 1'b0);
        step_and_check("vertical_border", 1'b0, 1'b0, 1'b0);
    endtask

    task automatic arc_bounds_test();
        clear_layout();
        layout[3] = make_piece(track_pkg::PIECE_ARC, 0, 200, 0, 200, 0, 0, 50, 150);
        write_layout();
        load_car(make_car(36, 36, -2, -1));
        step_and_check("arc_inner", 1'b0, 1'b1, 1'b0);
        load_car(make_car(110, 100, 1, 2));
        step_and_check("arc_outer", 1'b0, 1'b1, 1'b0);
        // A zero dot product keeps the outer bound from counting.
        load_car(make_car(110, 100, 10, -11));
        step_and_check("arc_tangent", 1'b0, 1'b0, 1'b0);
    endtask

    task automatic off_track_test();
        clear_layout();
        layout[0] = make_piece(track_pkg::PIECE_HORIZONTAL, 0, 100, 0, 100, 0, 0, 0, 0);
        write_layout();
        load_car(make_car(500, 500, 3, -4));
        step_and_check("off_track", 1'b0, 1'b0, 1'b1);
        apply_reset();
        check_reset_values("off_track_reset");
        // A bounce before the second reset leaves o_collided high.
        write_layout();
        load_car(make_car(50, 98, 0, 1));
        step_and_check("hit_before_reset", 1'b0, 1'b1, 1'b0);
        apply_reset();
        check_reset_values("hit_reset");
    endtask

    task automatic busy_strobes_test();
        int extra;
        extra = 0;
        clear_layout();
        layout[0] = make_piece(track_pkg::PIECE_HORIZONTAL, -1000, 1000, -100, 100,
                               0, 0, 0, 0);
        write_layout();
        load_car(make_car(0, 0, 4, -3));
        step_and_check("busy_strobes", 1'b1, 1'b0, 1'b0);
        repeat (8) begin
            @(negedge clk);
            if (done === 1'b1) extra++;
        end
        check_value("busy_strobes", "extra done pulses", 0, extra);
        check_value("busy_strobes", "car after idle", model_car, car_out);
    endtask

    initial begin
        #WATCHDOG_NS;
        stop_on_error("Watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h1520));
        reset       = 1'b1;
        piece_wr    = 1'b0;
        piece_index = '0;
        piece       = '0;
        load        = 1'b0;
        car_in      = '0;
        step        = 1'b0;
        model_car   = '0;
        apply_reset();
        check_reset_values("reset");
        free_motion_test();
        horizontal_border_test();
        vertical_border_test();
        arc_bounds_test();
        off_track_test();
        busy_strobes_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/race_track_props.sv
`default_nettype none

module race_track_props (
    input logic                   i_clk,
    input logic                   i_reset,
    input logic                   i_step,
    input track_pkg::step_state_e i_state,
    input logic                   i_done
);
    timeunit 1ns;
    timeprecision 100ps;

    logic step_accepted;

    assign step_accepted = !i_reset && i_step && (i_state == track_pkg::STEP_IDLE);

    done_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |=> !i_done)
        else $error("o_done stayed high for more than one cycle");

    // Done lands six cycles after the accepted step, and never otherwise.
    done_after_step: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(step_accepted, 6) |-> i_done)
        else $error("o_done missing six cycles after an accepted step");

    done_needs_step: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |-> $past(step_accepted, 6))
        else $error("o_done without an accepted step six cycles earlier");

    no_done_in_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_done)
        else $error("o_done high during reset");

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic o_clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period.
    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

// File: rtl/race_track_top.sv
`default_nettype none

module race_track_top (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_piece_wr,
    input  logic [track_pkg::PIECE_IDX_WIDTH-1:0] i_piece_index,
    input  track_pkg::track_piece_t               i_piece,
    input  logic                                  i_load,
    input  track_pkg::car_state_t                 i_car,
    input  logic                                  i_step,
    output track_pkg::car_state_t                 o_car,
    output logic                                  o_done,
    output logic                                  o_collided,
    output logic                                  o_off_track
);

    logic [track_pkg::PIECE_IDX_WIDTH-1:0] rd_index;
    track_pkg::track_piece_t               rd_piece;
    track_pkg::car_state_t                 held_car;
    track_pkg::hit_t                       straight_hit;
    track_pkg::hit_t                       arc_hit;

    track_store u_track_store (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr       (i_piece_wr),
        .i_wr_index (i_piece_index),
        .i_wr_piece (i_piece),
        .i_rd_index (rd_index),
        .o_rd_piece (rd_piece)
    );

    straight_collision u_straight_collision (
        .i_piece (rd_piece),
        .i_car   (held_car),
        .o_hit   (straight_hit)
    );

    arc_collision u_arc_collision (
        .i_piece (rd_piece),
        .i_car   (held_car),
        .o_hit   (arc_hit)
    );

    car_physics u_car_physics (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_load         (i_load),
        .i_car          (i_car),
        .i_step         (i_step),
        .o_rd_index     (rd_index),
        .i_straight_hit (straight_hit),
        .i_arc_hit      (arc_hit),
        .o_held_car     (held_car),
        .o_car          (o_car),
        .o_done         (o_done),
        .o_collided     (o_collided),
        .o_off_track    (o_off_track)
    );

endmodule

`default_nettype wire

// File: rtl/car_physics.sv
`default_nettype none

module car_physics (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_load,
    input  track_pkg::car_state_t                 i_car,
    input  logic                                  i_step,
    output logic [track_pkg::PIECE_IDX_WIDTH-1:0] o_rd_index,
    input  track_pkg::hit_t                       i_straight_hit,
    input  track_pkg::hit_t                       i_arc_hit,
    output track_pkg::car_state_t                 o_held_car,
    output track_pkg::car_state_t                 o_car,
    output logic                                  o_done,
    output logic                                  o_collided,
    output logic                                  o_off_track
);

    track_pkg::step_state_e                state;
    logic [track_pkg::PIECE_IDX_WIDTH-1:0] scan_idx;
    logic                                  rd_valid;
    track_pkg::hit_t                       merged;
    track_pkg::hit_t                       acc;
    track_pkg::hit_t                       final_hit;
    track_pkg::car_state_t                 car;
    logic                                  bounced;

    assign o_rd_index = scan_idx;
    assign o_held_car = car;
    assign o_car      = car;

    // Each checker is silent on kinds it does not own.
    assign merged = i_straight_hit | i_arc_hit;

    // In APPLY the last piece is still on the store output.
    assign final_hit = acc | merged;
    assign bounced   = final_hit.flip_x || final_hit.flip_y;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= track_pkg::STEP_IDLE;
            scan_idx    <= '0;
            rd_valid    <= 1'b0;
            acc         <= '0;
            car         <= '0;
            o_done      <= 1'b0;
            o_collided  <= 1'b0;
            o_off_track <= 1'b0;
        end else begin
            o_done   <= 1'b0;
            // Store data lags the index by one cycle.
            rd_valid <= (state == track_pkg::STEP_SCAN);

            case (state)
                track_pkg::STEP_IDLE: begin
                    if (i_load) begin
                        car <= i_car;
                    end
                    if (i_step) begin
                        state    <= track_pkg::STEP_SCAN;
                        scan_idx <= '0;
                        acc      <= '0;
                    end
                end

                track_pkg::STEP_SCAN: begin
                    if (rd_valid) begin
                        acc <= acc | merged;
                    end
                    scan_idx <= scan_idx + 1'b1;
                    if (scan_idx == track_pkg::PIECE_IDX_WIDTH'(track_pkg::NUM_PIECES - 1)) begin
                        state <= track_pkg::STEP_APPLY;
                    end
                end

                track_pkg::STEP_APPLY: begin
                    if (final_hit.flip_x) begin
                        car.vx <= -car.vx;
                    end
                    if (final_hit.flip_y) begin
                        car.vy <= -car.vy;
                    end
                    // Free move only when nothing bounced.
                    if (!bounced) begin
                        car.x <= car.x + {{(track_pkg::COORD_WIDTH - track_pkg::VEL_WIDTH)
                                          {car.vx[track_pkg::VEL_WIDTH-1]}}, car.vx};
                        car.y <= car.y + {{(track_pkg::COORD_WIDTH - track_pkg::VEL_WIDTH)
                                          {car.vy[track_pkg::VEL_WIDTH-1]}}, car.vy};
                    end
                    o_collided  <= bounced;
                    o_off_track <= !final_hit.in_region;
                    o_done      <= 1'b1;
                    state       <= track_pkg::STEP_IDLE;
                end

                default: begin
                    state <= track_pkg::STEP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/arc_collision.sv
`default_nettype none

module arc_collision (
    input  track_pkg::track_piece_t i_piece,
    input  track_pkg::car_state_t   i_car,
    output track_pkg::hit_t         o_hit
);

    logic                                         is_arc;
    logic                                         in_region;
    logic                                         going_inward;
    logic                                         going_outward;
    logic                                         bounce;
    logic signed [track_pkg::VEL_WIDTH-1:0]       car_vx;
    logic signed [track_pkg::VEL_WIDTH-1:0]       car_vy;
    logic signed [track_pkg::COORD_WIDTH:0]       disp_x;
    logic signed [track_pkg::COORD_WIDTH:0]       disp_y;
    logic signed [track_pkg::COORD_WIDTH:0]       bound_inner;
    logic signed [track_pkg::COORD_WIDTH:0]       bound_outer;
    logic signed [2*track_pkg::COORD_WIDTH+2:0]   dist_sq;
    logic signed [2*track_pkg::COORD_WIDTH+2:0]   inner_sq;
    logic signed [2*track_pkg::COORD_WIDTH+2:0]   outer_sq;
    logic signed [track_pkg::COORD_WIDTH+track_pkg::VEL_WIDTH+1:0] dot;

    assign car_vx = i_car.vx;
    assign car_vy = i_car.vy;

    assign is_arc    = (i_piece.kind == track_pkg::PIECE_ARC);
    assign in_region = is_arc && track_pkg::car_in_box(i_piece, i_car);

    // Vector from the arc centre to the car.
    assign disp_x = i_car.x - i_piece.center_x;
    assign disp_y = i_car.y - i_piece.center_y;

    assign dist_sq = disp_x * disp_x + disp_y * disp_y;

    assign bound_inner = i_piece.radius_inner + track_pkg::CAR_RADIUS;
    assign bound_outer = i_piece.radius_outer - track_pkg::CAR_RADIUS;
    assign inner_sq    = bound_inner * bound_inner;
    assign outer_sq    = bound_outer * bound_outer;

    // Sign of the dot product gives radial direction; zero means tangential.
    assign dot           = car_vx * disp_x + car_vy * disp_y;
    assign going_inward  = (dot < 0);
    assign going_outward = (dot > 0);

    assign bounce = in_region
                 && (((dist_sq <= inner_sq) && going_inward)
                  || ((dist_sq >= outer_sq) && going_outward));

    always_comb begin
        o_hit.in_region = in_region;
        o_hit.flip_x    = bounce;
        o_hit.flip_y    = bounce;
    end

endmodule

`default_nettype wire

// File: rtl/straight_collision.sv
`default_nettype none

module straight_collision (
    input  track_pkg::track_piece_t i_piece,
    input  track_pkg::car_state_t   i_car,
    output track_pkg::hit_t         o_hit
);

    logic                                 is_horizontal;
    logic                                 is_vertical;
    logic                                 in_box;
    logic signed [track_pkg::COORD_WIDTH-1:0] car_x;
    logic signed [track_pkg::COORD_WIDTH-1:0] car_y;
    logic signed [track_pkg::VEL_WIDTH-1:0]   car_vx;
    logic signed [track_pkg::VEL_WIDTH-1:0]   car_vy;
    logic signed [track_pkg::COORD_WIDTH:0]   dist_top;
    logic signed [track_pkg::COORD_WIDTH:0]   dist_bottom;
    logic signed [track_pkg::COORD_WIDTH:0]   dist_left;
    logic signed [track_pkg::COORD_WIDTH:0]   dist_right;
    logic                                 hit_y;
    logic                                 hit_x;

    assign car_x  = i_car.x;
    assign car_y  = i_car.y;
    assign car_vx = i_car.vx;
    assign car_vy = i_car.vy;

    assign is_horizontal = (i_piece.kind == track_pkg::PIECE_HORIZONTAL);
    assign is_vertical   = (i_piece.kind == track_pkg::PIECE_VERTICAL);
    assign in_box        = track_pkg::car_in_box(i_piece, i_car);

    // Gap between the car edge and each border goes negative once they overlap.
    assign dist_top    = i_piece.y_top - car_y - track_pkg::CAR_RADIUS;
    assign dist_bottom = car_y - track_pkg::CAR_RADIUS - i_piece.y_bottom;
    assign dist_left   = car_x - track_pkg::CAR_RADIUS - i_piece.x_left;
    assign dist_right  = i_piece.x_right - car_x - track_pkg::CAR_RADIUS;

    // Only a border the car is moving toward counts.
    assign hit_y = ((dist_top <= 0) && (car_vy > 0))
                || ((dist_bottom <= 0) && (car_vy < 0));
    assign hit_x = ((dist_left <= 0) && (car_vx < 0))
                || ((dist_right <= 0) && (car_vx > 0));

    always_comb begin
        o_hit           = '0;
        o_hit.in_region = (is_horizontal || is_vertical) && in_box;
        o_hit.flip_y    = is_horizontal && in_box && hit_y;
        o_hit.flip_x    = is_vertical && in_box && hit_x;
    end

endmodule

`default_nettype wire

// File: rtl/track_store.sv
`default_nettype none

module track_store (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_wr,
    input  logic [track_pkg::PIECE_IDX_WIDTH-1:0] i_wr_index,
    input  track_pkg::track_piece_t              i_wr_piece,
    input  logic [track_pkg::PIECE_IDX_WIDTH-1:0] i_rd_index,
    output track_pkg::track_piece_t              o_rd_piece
);

    track_pkg::track_piece_t pieces [track_pkg::NUM_PIECES];

    // Reset leaves zero-size horizontal pieces.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < track_pkg::NUM_PIECES; i++) begin
                pieces[i]      <= '0;
                pieces[i].kind <= track_pkg::PIECE_HORIZONTAL;
            end
        end else if (i_wr) begin
            pieces[i_wr_index] <= i_wr_piece;
        end
    end

    // Registered read with one cycle of latency.
    always_ff @(posedge i_clk) begin
        o_rd_piece <= pieces[i_rd_index];
    end

endmodule

`default_nettype wire

// File: rtl/track_pkg.sv
`default_nettype none

package track_pkg;

    localparam int COORD_WIDTH = 12;
    localparam int VEL_WIDTH = 8;
    localparam logic signed [COORD_WIDTH-1:0] CAR_RADIUS = 4;
    localparam int NUM_PIECES = 4;
    localparam int PIECE_IDX_WIDTH = 2;

    typedef enum logic [1:0] {
        PIECE_HORIZONTAL = 2'd0,
        PIECE_VERTICAL   = 2'd1,
        PIECE_ARC        = 2'd2
    } piece_kind_e;

    typedef enum logic [1:0] {
        STEP_IDLE  = 2'd0,
        STEP_SCAN  = 2'd1,
        STEP_APPLY = 2'd2
    } step_state_e;

    // For straights the box edges across the direction of travel are the borders.
    typedef struct packed {
        piece_kind_e                   kind;
        logic signed [COORD_WIDTH-1:0] x_left;
        logic signed [COORD_WIDTH-1:0] x_right;
        logic signed [COORD_WIDTH-1:0] y_bottom;
        logic signed [COORD_WIDTH-1:0] y_top;
        logic signed [COORD_WIDTH-1:0] center_x;
        logic signed [COORD_WIDTH-1:0] center_y;
        logic signed [COORD_WIDTH-1:0] radius_inner;
        logic signed [COORD_WIDTH-1:0] radius_outer;
    } track_piece_t;

    typedef struct packed {
        logic signed [COORD_WIDTH-1:0] x;
        logic signed [COORD_WIDTH-1:0] y;
        logic signed [VEL_WIDTH-1:0]   vx;
        logic signed [VEL_WIDTH-1:0]   vy;
    } car_state_t;

    typedef struct packed {
        logic flip_x;
        logic flip_y;
        logic in_region;
    } hit_t;

    // Car centre inside the piece box with inclusive edges.
    function automatic logic car_in_box(track_piece_t piece, car_state_t car);
        return ($signed(car.x) >= $signed(piece.x_left))
            && ($signed(car.x) <= $signed(piece.x_right))
            && ($signed(car.y) >= $signed(piece.y_bottom))
            && ($signed(car.y) <= $signed(piece.y_top));
    endfunction

endpackage

`default_nettype wire
